/* logic/ttt_pkg.sv */
package ttt_pkg;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [9:0] hcount_t;    // pixel within a line
	typedef logic [9:0] vcount_t;    // line within a frame
	typedef logic [5:0] local_t;     // 0..49 inside one tile
	typedef logic [3:0] tile_idx_t;  // 0..8, reading order
	typedef logic [8:0] marks_t;     // bit n for tile n

	typedef logic [2:0] red_t;
	typedef logic [2:0] green_t;
	typedef logic [1:0] blue_t;

	typedef enum logic [1:0]
	{
		REGION_BLANK,  // outside active area
		REGION_GRID,   // on a grid line
		REGION_TILE,   // inside a tile
		REGION_FIELD   // active but off the board
	} region_t;

	// ----------------------------------------
	// 640x480 timing, counted in pixel strobes
	// ----------------------------------------
	localparam int H_TOTAL = 800;
	localparam int V_TOTAL = 521;
	localparam int H_PULSE = 96;
	localparam int V_PULSE = 2;
	localparam int H_BP    = 144;  // first active pixel
	localparam int H_FP    = 784;  // first pixel past active
	localparam int V_BP    = 31;
	localparam int V_FP    = 511;

	// board and glyph geometry
	localparam int TILE_OFFSET = 10;
	localparam int TILE_WIDTH  = 50;
	localparam int LINE_THICK  = 2;
	localparam int RADIUS      = 15;  // inner radius of the O
	localparam int RING_THICK  = 2;
	localparam int X_HALF      = 1;

	// ----------------------------------------
	// colours
	// ----------------------------------------
	localparam red_t   GRID_R  = 3'd2;
	localparam green_t GRID_G  = 3'd4;
	localparam blue_t  GRID_B  = 2'd3;
	localparam red_t   MARK_R  = 3'd7;
	localparam green_t MARK_G  = 3'd7;
	localparam blue_t  MARK_B  = 2'd3;
	localparam red_t   FIELD_R = 3'd7;
	localparam green_t FIELD_G = 3'd7;
	localparam blue_t  FIELD_B = 2'd3;

	// tile background palette, one entry per tile
	localparam red_t   TILE_R [0:8] = '{3'd7, 3'd0, 3'd0, 3'd7, 3'd7, 3'd0, 3'd2, 3'd0, 3'd2};
	localparam green_t TILE_G [0:8] = '{3'd0, 3'd7, 3'd0, 3'd7, 3'd0, 3'd7, 3'd0, 3'd2, 3'd2};
	localparam blue_t  TILE_B [0:8] = '{2'd0, 2'd0, 2'd3, 2'd0, 2'd3, 2'd3, 2'd0, 2'd0, 2'd0};

endpackage

/* logic/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing
	import ttt_pkg::*;
#(
	parameter int H_TOTAL = ttt_pkg::H_TOTAL,
	parameter int V_TOTAL = ttt_pkg::V_TOTAL,
	parameter int H_PULSE = ttt_pkg::H_PULSE,
	parameter int V_PULSE = ttt_pkg::V_PULSE
)
(
	input  logic    clk,
	input  logic    rst,
	input  logic    i_pix_en,     // one clock in four
	output hcount_t o_hc,
	output vcount_t o_vc,
	output logic    o_hsync_raw,
	output logic    o_vsync_raw
);

	hcount_t hc;
	vcount_t vc;
	logic    line_end;
	logic    frame_end;

	assign line_end  = (hc == hcount_t'(H_TOTAL - 1));
	assign frame_end = (vc == vcount_t'(V_TOTAL - 1));

	// ----------------------------------------
	// raster counters
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			hc <= '0;
			vc <= '0;
		end
		else if (i_pix_en)
		begin
			if (line_end)
			begin
				hc <= '0;
				if (frame_end)
					vc <= '0;  // back to the top
				else
					vc <= vc + 1'b1;
			end
			else
			begin
				hc <= hc + 1'b1;
			end
		end
	end

	assign o_hc = hc;
	assign o_vc = vc;

	// syncs are active low at the start of line and frame
	assign o_hsync_raw = (hc >= hcount_t'(H_PULSE));
	assign o_vsync_raw = (vc >= vcount_t'(V_PULSE));

	// counters must wrap before reaching their totals
	hc_in_range: assert property (@(posedge clk) disable iff (rst)
		hc < hcount_t'(H_TOTAL))
		else $error("horizontal counter reached %0d", hc);

	vc_in_range: assert property (@(posedge clk) disable iff (rst)
		vc < vcount_t'(V_TOTAL))
		else $error("vertical counter reached %0d", vc);

endmodule

/* logic/board_geometry.sv */
`timescale 1ns/1ps

module board_geometry
	import ttt_pkg::*;
#(
	parameter int H_BP        = ttt_pkg::H_BP,
	parameter int H_FP        = ttt_pkg::H_FP,
	parameter int V_BP        = ttt_pkg::V_BP,
	parameter int V_FP        = ttt_pkg::V_FP,
	parameter int TILE_OFFSET = ttt_pkg::TILE_OFFSET,
	parameter int TILE_WIDTH  = ttt_pkg::TILE_WIDTH,
	parameter int LINE_THICK  = ttt_pkg::LINE_THICK
)
(
	input  hcount_t   i_hc,
	input  vcount_t   i_vc,
	output region_t   o_region,
	output tile_idx_t o_tile_idx,
	output local_t    o_local_x,
	output local_t    o_local_y
);

	localparam int H_START = H_BP + TILE_OFFSET;  // board's left edge
	localparam int V_START = V_BP + TILE_OFFSET;  // board's top edge
	localparam int STEP    = TILE_WIDTH + LINE_THICK;
	localparam int SPAN    = 3 * TILE_WIDTH + 2 * LINE_THICK;

	logic       active;
	logic       col_span;
	logic       col_line;
	logic [1:0] col_band;
	local_t     col_loc;
	logic       row_span;
	logic       row_line;
	logic [1:0] row_band;
	local_t     row_loc;

	// ----------------------------------------
	// one axis of the board
	// ----------------------------------------
	// pos is relative to the board edge and may be negative
	function automatic void split_axis(
		input  int         pos,
		output logic       in_span,
		output logic       on_line,
		output logic [1:0] band,
		output local_t     loc
	);
		int rel;
		in_span = (pos >= 0) && (pos < SPAN);
		on_line = 1'b0;
		band    = 2'd0;
		loc     = '0;
		for (int i = 0; i < 3; i++)
		begin
			rel = pos - i * STEP;
			if (rel >= 0 && rel < TILE_WIDTH)
			begin
				band = 2'(i);
				loc  = local_t'(rel);  // offset from tile's own edge
			end
			else if (i < 2 && rel >= TILE_WIDTH && rel < STEP)
			begin
				on_line = 1'b1;
			end
		end
	endfunction

	always_comb
	begin
		split_axis(int'(i_hc) - H_START, col_span, col_line, col_band, col_loc);
		split_axis(int'(i_vc) - V_START, row_span, row_line, row_band, row_loc);
	end

	assign active = (i_hc >= hcount_t'(H_BP)) && (i_hc < hcount_t'(H_FP))
		&& (i_vc >= vcount_t'(V_BP)) && (i_vc < vcount_t'(V_FP));

	// region priority: blank, grid, tile, field
	always_comb
	begin
		if (!active)
			o_region = REGION_BLANK;
		else if ((col_line && row_span) || (row_line && col_span))
			o_region = REGION_GRID;  // a line crossing the board
		else if (col_span && row_span)
			o_region = REGION_TILE;
		else
			o_region = REGION_FIELD;
	end

	assign o_tile_idx = tile_idx_t'(row_band * 3 + col_band);
	assign o_local_x  = col_loc;
	assign o_local_y  = row_loc;

	tile_idx_range: assert final (o_region != REGION_TILE || o_tile_idx < tile_idx_t'(9))
		else $error("tile index %0d out of range", o_tile_idx);

endmodule

/* logic/glyph_raster.sv */
`timescale 1ns/1ps

module glyph_raster
	import ttt_pkg::*;
#(
	parameter int TILE_WIDTH = ttt_pkg::TILE_WIDTH,
	parameter int RADIUS     = ttt_pkg::RADIUS,
	parameter int RING_THICK = ttt_pkg::RING_THICK,
	parameter int X_HALF     = ttt_pkg::X_HALF
)
(
	input  local_t i_local_x,
	input  local_t i_local_y,
	output logic   o_on_o,
	output logic   o_on_x
);

	localparam int CENTRE   = TILE_WIDTH / 2;
	localparam int R_IN_SQ  = RADIUS * RADIUS;
	localparam int R_OUT_SQ = (RADIUS + RING_THICK) * (RADIUS + RING_THICK);

	int dx;
	int dy;
	int dist_sq;
	int diag_main;  // zero on the x == y diagonal
	int diag_anti;  // zero on the x + y == width - 1 diagonal

	// ----------------------------------------
	// O ring
	// ----------------------------------------
	always_comb
	begin
		dx      = int'(i_local_x) - CENTRE;
		dy      = int'(i_local_y) - CENTRE;
		dist_sq = dx * dx + dy * dy;
	end

	// inner edge inclusive, outer edge exclusive
	assign o_on_o = (dist_sq >= R_IN_SQ) && (dist_sq < R_OUT_SQ);

	// ----------------------------------------
	// X bands
	// ----------------------------------------
	always_comb
	begin
		diag_main = int'(i_local_x) - int'(i_local_y);
		diag_anti = int'(i_local_x) + int'(i_local_y) - (TILE_WIDTH - 1);
	end

	assign o_on_x = ((diag_main >= -X_HALF) && (diag_main <= X_HALF))
		|| ((diag_anti >= -X_HALF) && (diag_anti <= X_HALF));

endmodule

/* logic/pixel_shader.sv */
`timescale 1ns/1ps

module pixel_shader
	import ttt_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_pix_en,
	input  region_t   i_region,
	input  tile_idx_t i_tile_idx,
	input  logic      i_on_o,
	input  logic      i_on_x,
	input  marks_t    i_o_marks,
	input  marks_t    i_x_marks,
	input  logic      i_hsync_raw,
	input  logic      i_vsync_raw,
	output logic      o_hsync,
	output logic      o_vsync,
	output red_t      o_red,
	output green_t    o_green,
	output blue_t     o_blue
);

	red_t   red_nxt;
	green_t green_nxt;
	blue_t  blue_nxt;
	logic   o_set;
	logic   x_set;
	logic   mark_hit;

	// ----------------------------------------
	// colour selection
	// ----------------------------------------
	assign o_set = i_o_marks[i_tile_idx];
	assign x_set = i_x_marks[i_tile_idx];

	// O takes precedence over X on the same tile
	assign mark_hit = (o_set && i_on_o) || (!o_set && x_set && i_on_x);

	always_comb
	begin
		case (i_region)
			REGION_GRID:
			begin
				red_nxt   = GRID_R;
				green_nxt = GRID_G;
				blue_nxt  = GRID_B;
			end
			REGION_FIELD:
			begin
				red_nxt   = FIELD_R;
				green_nxt = FIELD_G;
				blue_nxt  = FIELD_B;
			end
			REGION_TILE:
			begin
				if (mark_hit)
				begin
					red_nxt   = MARK_R;
					green_nxt = MARK_G;
					blue_nxt  = MARK_B;
				end
				else
				begin
					red_nxt   = TILE_R[i_tile_idx];  // tile background
					green_nxt = TILE_G[i_tile_idx];
					blue_nxt  = TILE_B[i_tile_idx];
				end
			end
			default:
			begin
				red_nxt   = '0;  // blanking
				green_nxt = '0;
				blue_nxt  = '0;
			end
		endcase
	end

	// ----------------------------------------
	// output registers, one pixel of latency
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			o_red   <= '0;
			o_green <= '0;
			o_blue  <= '0;
			o_hsync <= 1'b1;  // inactive
			o_vsync <= 1'b1;
		end
		else if (i_pix_en)
		begin
			o_red   <= red_nxt;
			o_green <= green_nxt;
			o_blue  <= blue_nxt;
			o_hsync <= i_hsync_raw;  // kept aligned with colour
			o_vsync <= i_vsync_raw;
		end
	end

	blank_is_black: assert property (@(posedge clk) disable iff (rst)
		(i_pix_en && i_region == REGION_BLANK) |=> (o_red == '0 && o_green == '0 && o_blue == '0))
		else $error("colour not black during blanking");

endmodule

/* logic/ttt_vga_top.sv */
`timescale 1ns/1ps

module ttt_vga_top
	import ttt_pkg::*;
#(
	parameter int H_TOTAL     = ttt_pkg::H_TOTAL,
	parameter int V_TOTAL     = ttt_pkg::V_TOTAL,
	parameter int H_PULSE     = ttt_pkg::H_PULSE,
	parameter int V_PULSE     = ttt_pkg::V_PULSE,
	parameter int H_BP        = ttt_pkg::H_BP,
	parameter int H_FP        = ttt_pkg::H_FP,
	parameter int V_BP        = ttt_pkg::V_BP,
	parameter int V_FP        = ttt_pkg::V_FP,
	parameter int TILE_OFFSET = ttt_pkg::TILE_OFFSET,
	parameter int TILE_WIDTH  = ttt_pkg::TILE_WIDTH,
	parameter int LINE_THICK  = ttt_pkg::LINE_THICK,
	parameter int RADIUS      = ttt_pkg::RADIUS,
	parameter int RING_THICK  = ttt_pkg::RING_THICK,
	parameter int X_HALF      = ttt_pkg::X_HALF
)
(
	input  logic   clk,
	input  logic   rst,
	input  logic   i_pix_en,
	input  marks_t i_o_marks,
	input  marks_t i_x_marks,
	output logic   o_hsync,
	output logic   o_vsync,
	output red_t   o_red,
	output green_t o_green,
	output blue_t  o_blue
);

	hcount_t   hc;
	vcount_t   vc;
	logic      hsync_raw;
	logic      vsync_raw;
	region_t   region;
	tile_idx_t tile_idx;
	local_t    local_x;
	local_t    local_y;
	logic      on_o;
	logic      on_x;

	vga_timing #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL), .H_PULSE(H_PULSE), .V_PULSE(V_PULSE))
	vga_timing_i (.clk(clk), .rst(rst), .i_pix_en(i_pix_en), .o_hc(hc), .o_vc(vc),
		.o_hsync_raw(hsync_raw), .o_vsync_raw(vsync_raw));

	board_geometry #(.H_BP(H_BP), .H_FP(H_FP), .V_BP(V_BP), .V_FP(V_FP),
		.TILE_OFFSET(TILE_OFFSET), .TILE_WIDTH(TILE_WIDTH), .LINE_THICK(LINE_THICK))
	board_geometry_i (.i_hc(hc), .i_vc(vc), .o_region(region), .o_tile_idx(tile_idx),
		.o_local_x(local_x), .o_local_y(local_y));

	glyph_raster #(.TILE_WIDTH(TILE_WIDTH), .RADIUS(RADIUS), .RING_THICK(RING_THICK),
		.X_HALF(X_HALF))
	glyph_raster_i (.i_local_x(local_x), .i_local_y(local_y), .o_on_o(on_o), .o_on_x(on_x));

	// registered outputs
	pixel_shader pixel_shader_i (
		.clk(clk), .rst(rst), .i_pix_en(i_pix_en),
		.i_region(region), .i_tile_idx(tile_idx),
		.i_on_o(on_o), .i_on_x(on_x),
		.i_o_marks(i_o_marks), .i_x_marks(i_x_marks),
		.i_hsync_raw(hsync_raw), .i_vsync_raw(vsync_raw),
		.o_hsync(o_hsync), .o_vsync(o_vsync),
		.o_red(o_red), .o_green(o_green), .o_blue(o_blue)
	);

endmodule

/* test/ttt_vga_tb.sv */
`timescale 1ns/1ps

module ttt_vga_tb
	import ttt_pkg::*;
();

	localparam int LEAD = 8;  // marks settle this many pixels early
	localparam int H0   = H_BP + TILE_OFFSET;
	localparam int V0   = V_BP + TILE_OFFSET;
	localparam int STEP = TILE_WIDTH + LINE_THICK;
	localparam marks_t NO_MARKS = '0;

	logic   clk;
	logic   rst;
	logic   i_pix_en;
	marks_t i_o_marks;
	marks_t i_x_marks;
	logic   o_hsync;
	logic   o_vsync;
	red_t   o_red;
	green_t o_green;
	blue_t  o_blue;

	int strobes;      // pixel strobes since the last reset
	bit table_ready;

	// stimulus table, one entry per checked pixel
	marks_t row_o_marks [$];
	marks_t row_x_marks [$];
	int     row_col [$];
	int     row_line [$];
	red_t   row_r [$];
	green_t row_g [$];
	blue_t  row_b [$];
	logic   row_hs [$];
	logic   row_vs [$];

	ttt_vga_top ttt_vga_top_i (
		.clk(clk), .rst(rst), .i_pix_en(i_pix_en),
		.i_o_marks(i_o_marks), .i_x_marks(i_x_marks),
		.o_hsync(o_hsync), .o_vsync(o_vsync),
		.o_red(o_red), .o_green(o_green), .o_blue(o_blue)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ----------------------------------------
	// reporting and compare tasks
	// ----------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_rgb(input red_t exp_r, input green_t exp_g, input blue_t exp_b,
		input string where);
		if (o_red !== exp_r)
			stop_on_error($sformatf("CHECK FAILED o_red expected 0x%0h actual 0x%0h (%s)",
				exp_r, o_red, where));
		if (o_green !== exp_g)
			stop_on_error($sformatf("CHECK FAILED o_green expected 0x%0h actual 0x%0h (%s)",
				exp_g, o_green, where));
		if (o_blue !== exp_b)
			stop_on_error($sformatf("CHECK FAILED o_blue expected 0x%0h actual 0x%0h (%s)",
				exp_b, o_blue, where));
	endtask

	task automatic check_sync(input logic exp_hs, input logic exp_vs, input string where);
		if (o_hsync !== exp_hs)
			stop_on_error($sformatf("CHECK FAILED o_hsync expected 0x%0h actual 0x%0h (%s)",
				exp_hs, o_hsync, where));
		if (o_vsync !== exp_vs)
			stop_on_error($sformatf("CHECK FAILED o_vsync expected 0x%0h actual 0x%0h (%s)",
				exp_vs, o_vsync, where));
	endtask

	// black with both syncs inactive
	task automatic check_idle_outputs(input string where);
		check_rgb('0, '0, '0, where);
		check_sync(1'b1, 1'b1, where);
	endtask

	// ----------------------------------------
	// strobe and position model
	// ----------------------------------------
	task automatic pixel_step();
		i_pix_en = 1'b1;
		@(posedge clk);
		#1;
		i_pix_en = 1'b0;
		strobes++;  // outputs now show position strobes - 1
		repeat (3)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic advance_to(input int count);
		while (strobes < count)
			pixel_step();
	endtask

	// ----------------------------------------
	// table building
	// ----------------------------------------
	function automatic int tile_left(input int n);
		return H0 + (n % 3) * STEP;
	endfunction

	function automatic int tile_top(input int n);
		return V0 + (n / 3) * STEP;
	endfunction

	task automatic add_row(input marks_t o_m, input marks_t x_m, input int col, input int line,
		input red_t r, input green_t g, input blue_t b, input logic hs, input logic vs);
		row_o_marks.push_back(o_m);
		row_x_marks.push_back(x_m);
		row_col.push_back(col);
		row_line.push_back(line);
		row_r.push_back(r);
		row_g.push_back(g);
		row_b.push_back(b);
		row_hs.push_back(hs);
		row_vs.push_back(vs);
	endtask

	task automatic add_black(input int col, input int line, input logic hs, input logic vs);
		add_row(NO_MARKS, NO_MARKS, col, line, '0, '0, '0, hs, vs);
	endtask

	task automatic add_field(input int col, input int line);
		add_row(NO_MARKS, NO_MARKS, col, line, FIELD_R, FIELD_G, FIELD_B, 1'b1, 1'b1);
	endtask

	task automatic add_grid(input int col, input int line);
		add_row(NO_MARKS, NO_MARKS, col, line, GRID_R, GRID_G, GRID_B, 1'b1, 1'b1);
	endtask

	// dx, dy are tile-local; mark selects white over the palette
	task automatic add_tile(input marks_t o_m, input marks_t x_m, input int n,
		input int dx, input int dy, input bit mark);
		if (mark)
			add_row(o_m, x_m, tile_left(n) + dx, tile_top(n) + dy,
				MARK_R, MARK_G, MARK_B, 1'b1, 1'b1);
		else
			add_row(o_m, x_m, tile_left(n) + dx, tile_top(n) + dy,
				TILE_R[n], TILE_G[n], TILE_B[n], 1'b1, 1'b1);
	endtask

	task automatic build_table();
		// sync pulses and porches
		add_black(0, 0, 1'b0, 1'b0);
		add_black(H_PULSE - 1, 0, 1'b0, 1'b0);
		add_black(H_PULSE, 0, 1'b1, 1'b0);
		add_black(H_TOTAL - 1, V_PULSE - 1, 1'b1, 1'b0);
		add_black(0, V_PULSE, 1'b0, 1'b1);
		add_black(H_PULSE, V_PULSE, 1'b1, 1'b1);
		add_black(H_BP - 1, V_BP, 1'b1, 1'b1);
		add_field(H_BP, V_BP);  // first active pixel
		add_field(H_FP - 1, V_BP);
		add_black(H_FP, V_BP, 1'b1, 1'b1);
		// top row of tiles and the vertical lines
		add_grid(H0 + TILE_WIDTH, V0);
		add_tile(NO_MARKS, NO_MARKS, 0, 3, 5, 1'b0);
		add_tile(NO_MARKS, NO_MARKS, 1, 3, 5, 1'b0);
		add_tile(NO_MARKS, NO_MARKS, 2, 3, 5, 1'b0);
		add_grid(H0 + TILE_WIDTH + 1, V0 + 19);
		add_grid(H0 + STEP + TILE_WIDTH, V0 + 19);
		// tile 2 with both marks, O rule wins
		add_tile(9'b000000100, 9'b000000100, 2, 25, 25, 1'b0);
		add_tile(9'b000000100, 9'b000000100, 2, 25 + RADIUS, 25, 1'b1);
		// first horizontal line, then just past its end
		add_grid(H0, V0 + TILE_WIDTH);
		add_grid(H0 + 3 * TILE_WIDTH + 2 * LINE_THICK - 1, V0 + TILE_WIDTH + 1);
		add_field(H0 + 3 * TILE_WIDTH + 2 * LINE_THICK, V0 + TILE_WIDTH + 1);
		add_tile(NO_MARKS, NO_MARKS, 3, 3, 5, 1'b0);
		add_tile(NO_MARKS, NO_MARKS, 4, 3, 5, 1'b0);
		add_tile(NO_MARKS, NO_MARKS, 5, 3, 5, 1'b0);
		// O on tile 4, centre then ring
		add_tile(9'b000010000, NO_MARKS, 4, 25, 25, 1'b0);
		add_tile(9'b000010000, NO_MARKS, 4, 25 + RADIUS, 25, 1'b1);
		add_grid(H0 + 46, V0 + STEP + TILE_WIDTH);
		add_field(H0 + 3 * TILE_WIDTH + 2 * LINE_THICK, V0 + STEP + TILE_WIDTH + 1);
		add_tile(NO_MARKS, NO_MARKS, 6, 3, 5, 1'b0);
		add_tile(NO_MARKS, NO_MARKS, 7, 3, 5, 1'b0);
		add_tile(NO_MARKS, NO_MARKS, 8, 3, 5, 1'b0);
		// X on tile 7, on and off the diagonal
		add_tile(NO_MARKS, 9'b010000000, 7, 10, 10, 1'b1);
		add_tile(NO_MARKS, 9'b010000000, 7, 10, 30, 1'b0);
		add_field(H0 + TILE_WIDTH, V0 + 3 * TILE_WIDTH + 2 * LINE_THICK);  // below the board
	endtask

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial
	begin
		int max_line;
		int limit;
		wait (table_ready);
		max_line = 0;
		foreach (row_line[i])
			if (row_line[i] > max_line)
				max_line = row_line[i];
		limit = (max_line + 2) * H_TOTAL * 4 + 10;  // four clocks per pixel, plus reset
		repeat (limit) @(posedge clk);
		stop_on_error($sformatf("timeout: the run did not finish within %0d clock periods",
			limit));
	end

	// ----------------------------------------
	// main sequence
	// ----------------------------------------
	initial
	begin
		int pos;
		string where;
		rst = 1'b1;
		i_pix_en = 1'b0;
		i_o_marks = '0;
		i_x_marks = '0;
		strobes = 0;
		build_table();
		table_ready = 1'b1;

		@(posedge clk);
		#1;
		check_idle_outputs("during reset");
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (2)
		begin
			@(posedge clk);
			#1;
		end
		check_idle_outputs("after reset, before first strobe");

		foreach (row_col[i])
		begin
			pos = row_line[i] * H_TOTAL + row_col[i];
			where = $sformatf("row %0d line %0d col %0d", i, row_line[i], row_col[i]);
			advance_to(pos - LEAD);
			i_o_marks = row_o_marks[i];
			i_x_marks = row_x_marks[i];
			advance_to(pos + 1);  // one strobe of latency
			check_rgb(row_r[i], row_g[i], row_b[i], where);
			check_sync(row_hs[i], row_vs[i], where);
		end

		// second reset mid-frame, raster restarts at position 0
		rst = 1'b1;
		i_o_marks = '0;
		i_x_marks = '0;
		repeat (3) @(posedge clk);
		#1;
		check_idle_outputs("second reset");
		rst = 1'b0;
		strobes = 0;
		@(posedge clk);
		#1;
		check_idle_outputs("second reset, before first strobe");
		advance_to(1);
		check_rgb('0, '0, '0, "restart position 0");
		check_sync(1'b0, 1'b0, "restart position 0");
		advance_to(H_PULSE + 1);
		check_sync(1'b1, 1'b0, "restart end of hsync pulse");

		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* ttt_vga_top.f */
logic/ttt_pkg.sv
logic/vga_timing.sv
logic/board_geometry.sv
logic/glyph_raster.sv
logic/pixel_shader.sv
logic/ttt_vga_top.sv
test/ttt_vga_tb.sv
